/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := fetch_tb
FILELIST  := fetch_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/cpu_cache_if.sv */
`timescale 1ns/1ns
`default_nettype none

// request/response link between the fetch unit and the instruction cache
// a request is taken when req_valid and idle are both high at a clock edge
interface cpu_cache_if;

    fetch_pkg::pc_t    addr;
    logic              req_valid;
    fetch_pkg::fword_t rdata;
    // single-cycle pulse, rdata is only meaningful here
    logic              resp_valid;
    logic              idle;

    modport fetch (
        output addr,
        output req_valid,
        input  rdata,
        input  resp_valid,
        input  idle
    );

    modport cache (
        input  addr,
        input  req_valid,
        output rdata,
        output resp_valid,
        output idle
    );

endinterface

`default_nettype wire

/* common/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// program counter value after reset
// points at the start of main memory
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// number of lines in the direct-mapped instruction cache
// keep this a power of two, the index is taken straight from the pc
`define ICACHE_SETS 16

// cache line size in bytes
// one line is one memory transfer of 128 bits
`define ICACHE_LINE_BYTES 16

`endif

/* common/fetch_pkg.sv */
`default_nettype none

// types seen on the core side of the fetch path
package fetch_pkg;

    // byte address as used by the core, also the program counter
    typedef logic [63:0] pc_t;

    // one uncompressed instruction
    typedef logic [31:0] instr_t;

    // aligned doubleword returned by the cache
    // holds two instructions, pc bit 2 picks one
    typedef logic [63:0] fword_t;

endpackage

`default_nettype wire

/* common/mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

// line refill port from the instruction cache to memory
// valid stays up until ready, the ready cycle also carries rdata
interface mem_if;

    mem_pkg::laddr_t addr;
    logic            valid;
    mem_pkg::line_t  rdata;
    logic            ready;

    modport cache (
        output addr,
        output valid,
        input  rdata,
        input  ready
    );

    modport mem (
        input  addr,
        input  valid,
        output rdata,
        output ready
    );

endinterface

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

// types seen on the memory side of the instruction cache
package mem_pkg;

    // one full cache line as delivered by memory
    typedef logic [127:0] line_t;

    // line-aligned byte address, low four bits are always zero
    typedef logic [63:0] laddr_t;

endpackage

`default_nettype wire

/* dv/fetch_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

// line memory for the fetch testbench
// the 32-bit word at byte address a holds {a[31:2] ^ 30'h1234567, 2'b00}
module fetch_mem_model (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            valid_i,
    input  wire mem_pkg::laddr_t addr_i,
    output mem_pkg::line_t       rdata_o,
    output logic                 ready_o,
    output int unsigned          req_count_o
);

    mem_pkg::line_t rdata_q     = '0;
    logic           ready_q     = 1'b0;
    int unsigned    req_count_q = 0;
    int unsigned    wait_q;
    logic           busy_q;

    function automatic mem_pkg::line_t line_at(input mem_pkg::laddr_t addr);
        mem_pkg::line_t line;
        logic [63:0]    a;
        int             i;
        for (i = 0; i < 4; i++) begin
            a = addr + 64'(4 * i);
            line[32*i +: 32] = {a[31:2] ^ 30'h1234567, 2'b00};
        end
        return line;
    endfunction

    // the response changes on the falling edge like every other tb input
    always @(negedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            ready_q     <= 1'b0;
            req_count_q <= 0;
        end else if (ready_q) begin
            // one ready cycle per request, the cache drops valid after it
            ready_q <= 1'b0;
            busy_q  <= 1'b0;
        end else if (busy_q) begin
            if (wait_q <= 1) begin
                ready_q <= 1'b1;
                rdata_q <= line_at(addr_i);
            end else begin
                wait_q <= wait_q - 1;
            end
        end else if (valid_i) begin
            // 1 to 6 cycles until ready
            busy_q      <= 1'b1;
            wait_q      <= 1 + $urandom % 6;
            req_count_q <= req_count_q + 1;
        end
    end

    assign rdata_o     = rdata_q;
    assign ready_o     = ready_q;
    assign req_count_o = req_count_q;

endmodule

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

    localparam int SEQ_LEN       = 64;
    localparam int RAND_JUMPS    = 40;
    localparam int BLOCK_CYCLES  = 6;
    localparam int WAIT_LIMIT    = 20;
    // accept, lookup, up to 6 memory cycles, fill and response
    localparam int REFILL_CYCLES = 10;
    localparam int NUM_FETCHES   = 1 + 2 * SEQ_LEN + 1 + RAND_JUMPS + 2;

    localparam fetch_pkg::pc_t SEQ_BASE = `FETCH_RESET_PC + 64'h400;
    // same index as SEQ_BASE, next tag up
    localparam fetch_pkg::pc_t ALIAS_PC = SEQ_BASE + 64'(`ICACHE_SETS * `ICACHE_LINE_BYTES);
    localparam fetch_pkg::pc_t BLOCK_TARGET = `FETCH_RESET_PC + 64'h800;

    logic              clk;
    logic              rst;
    logic              dnpc_valid;
    logic              block;
    fetch_pkg::pc_t    dnpc;
    logic              id_en;
    fetch_pkg::pc_t    pc;
    fetch_pkg::instr_t instr;
    logic              if_busy;
    logic              mem_valid;
    mem_pkg::laddr_t   mem_addr;
    mem_pkg::line_t    mem_rdata;
    logic              mem_ready;
    int unsigned       req_count;

    int             check_count = 0;
    int             error_count = 0;
    int             test_count  = 0;
    int             checks0;
    int             errors0;
    int unsigned    reqs0;
    fetch_pkg::pc_t held_pc;
    fetch_pkg::pc_t jump_pc;
    int             i;

    fetch_top fetch_top_inst (
        .clk          (clk),
        .rst          (rst),
        .dnpc_valid_i (dnpc_valid),
        .block_i      (block),
        .dnpc_i       (dnpc),
        .id_en_i      (id_en),
        .pc_o         (pc),
        .instr_o      (instr),
        .if_busy_o    (if_busy),
        .mem_valid_o  (mem_valid),
        .mem_addr_o   (mem_addr),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    fetch_mem_model mem_model_inst (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (mem_valid),
        .addr_i      (mem_addr),
        .rdata_o     (mem_rdata),
        .ready_o     (mem_ready),
        .req_count_o (req_count)
    );

    // memory word rule, independent of the cache organisation
    function automatic fetch_pkg::instr_t expected_instr(input fetch_pkg::pc_t addr);
        return {addr[31:2] ^ 30'h1234567, 2'b00};
    endfunction

    // start address of the memory line that holds a byte address
    function automatic mem_pkg::laddr_t line_of(input fetch_pkg::pc_t addr);
        return addr & ~64'(`ICACHE_LINE_BYTES - 1);
    endfunction

    // word-aligned pc inside a 4 KB window above the reset pc
    function automatic fetch_pkg::pc_t random_pc();
        return `FETCH_RESET_PC + 64'(($urandom % 1024) * 4);
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (if_busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (if_busy) begin
            $display("error at %0t: no instruction delivered for pc %h", $time, pc);
            error_count++;
        end
    endtask

    // decode takes the instruction, optionally with the next pc in the same cycle
    task automatic consume(input logic load, input fetch_pkg::pc_t next_pc);
        id_en      = 1'b1;
        dnpc_valid = load;
        dnpc       = next_pc;
        @(negedge clk);
        id_en      = 1'b0;
        dnpc_valid = 1'b0;
    endtask

    task automatic hold_for(input int cycles, input fetch_pkg::pc_t at_pc);
        fetch_pkg::instr_t expected;
        int                k;
        expected = expected_instr(at_pc);
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (instr !== expected) begin
                $display("mismatch at %0t: instr_o got %h expected %h",
                         $time, instr, expected);
                error_count++;
            end
            if (if_busy !== 1'b0) begin
                $display("mismatch at %0t: if_busy_o got %b expected 0", $time, if_busy);
                error_count++;
            end
        end
    endtask

    task automatic run_sequential(input fetch_pkg::pc_t start, input int count,
                                  input fetch_pkg::pc_t after);
        fetch_pkg::pc_t addr;
        int             k;
        addr = start;
        for (k = 0; k < count; k++) begin
            wait_ready();
            addr = (k == count - 1) ? after : addr + 64'd4;
            consume(1'b1, addr);
        end
    endtask

    task automatic check_requests(input int unsigned expected);
        if (req_count - reqs0 != expected) begin
            $display("mismatch at %0t: req_count got %0d expected %0d",
                     $time, req_count - reqs0, expected);
            error_count++;
        end
    endtask

    task automatic begin_test();
        checks0 = check_count;
        errors0 = error_count;
        reqs0   = req_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s: %0d instructions checked, %0d errors",
                 name, check_count - checks0, error_count - errors0);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // compare process, one check per consumed instruction
    always @(posedge clk) begin
        if (!rst && id_en && !if_busy) begin
            check_count++;
            if (instr !== expected_instr(pc)) begin
                $display("mismatch at %0t: instr_o got %h expected %h (pc_o %h)",
                         $time, instr, expected_instr(pc), pc);
                error_count++;
            end
        end
        // a refill always asks for the line of the pc being fetched
        if (!rst && mem_valid && mem_addr !== line_of(pc)) begin
            $display("mismatch at %0t: mem_addr_o got %h expected %h",
                     $time, mem_addr, line_of(pc));
            error_count++;
        end
    end

    initial begin
        repeat (NUM_FETCHES * REFILL_CYCLES * 4) @(posedge clk);
        $display("error at %0t: watchdog expired before the tests finished", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h0541_ccf6));
        rst        = 1'b1;
        dnpc_valid = 1'b0;
        block      = 1'b0;
        dnpc       = '0;
        id_en      = 1'b0;
        repeat (2) @(negedge clk);
        begin_test();
        if (pc !== `FETCH_RESET_PC) begin
            $display("mismatch at %0t: pc_o got %h expected %h", $time, pc, `FETCH_RESET_PC);
            error_count++;
        end
        if (mem_valid !== 1'b0) begin
            $display("mismatch at %0t: mem_valid_o got %b expected 0", $time, mem_valid);
            error_count++;
        end
        if (if_busy !== 1'b1) begin
            $display("mismatch at %0t: if_busy_o got %b expected 1", $time, if_busy);
            error_count++;
        end
        rst = 1'b0;

        wait_ready();
        if (pc !== `FETCH_RESET_PC) begin
            $display("mismatch at %0t: pc_o got %h expected %h", $time, pc, `FETCH_RESET_PC);
            error_count++;
        end
        consume(1'b1, SEQ_BASE);
        end_test("test 1 reset fetch");

        begin_test();
        run_sequential(SEQ_BASE, SEQ_LEN, SEQ_BASE);
        check_requests(SEQ_LEN / 4);
        end_test("test 2 sequential fetch");

        // all lines are present now, then one conflicting tag
        begin_test();
        run_sequential(SEQ_BASE, SEQ_LEN, ALIAS_PC);
        check_requests(0);
        reqs0 = req_count;
        wait_ready();
        jump_pc = random_pc();
        consume(1'b1, jump_pc);
        check_requests(1);
        end_test("test 3 refetch and tag conflict");

        begin_test();
        for (i = 0; i < RAND_JUMPS; i++) begin
            wait_ready();
            hold_for($urandom % 5, jump_pc);
            jump_pc = random_pc();
            consume(1'b1, jump_pc);
        end
        end_test("test 4 random jumps with decode stalls");

        begin_test();
        wait_ready();
        held_pc = pc;
        block   = 1'b1;
        for (i = 0; i < BLOCK_CYCLES; i++) begin
            dnpc_valid = i[0];
            dnpc       = held_pc + 64'(8 * (i + 1));
            @(negedge clk);
            if (pc !== held_pc) begin
                $display("mismatch at %0t: pc_o got %h expected %h", $time, pc, held_pc);
                error_count++;
            end
        end
        block      = 1'b0;
        dnpc_valid = 1'b0;
        consume(1'b1, BLOCK_TARGET);
        wait_ready();
        if (pc !== BLOCK_TARGET) begin
            $display("mismatch at %0t: pc_o got %h expected %h", $time, pc, BLOCK_TARGET);
            error_count++;
        end
        consume(1'b0, '0);
        end_test("test 5 blocked pipeline");

        $display("%0d tests, %0d instructions checked, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_top.f */
+incdir+common
common/fetch_pkg.sv
common/mem_pkg.sv
common/cpu_cache_if.sv
common/mem_if.sv
ifu/ifu_fetch.sv
icache/icache.sv
source/fetch_top.sv
dv/fetch_mem_model.sv
dv/fetch_tb.sv

/* icache/icache.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_params.svh"

module icache (
    input  wire logic  clk,
    input  wire logic  rst,
    cpu_cache_if.cache cpu,
    mem_if.cache       mem
);

    localparam int unsigned OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
    localparam int unsigned INDEX_W  = $clog2(`ICACHE_SETS);
    localparam int unsigned ADDR_W   = $bits(fetch_pkg::pc_t);
    localparam int unsigned TAG_W    = ADDR_W - OFFSET_W - INDEX_W;
    localparam int unsigned FWORD_W  = $bits(fetch_pkg::fword_t);

    // doubleword position inside the line, one bit for 16-byte lines
    localparam int unsigned WSEL_W = OFFSET_W - 3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } state_e;

    state_e state_q;
    state_e state_d;

    // request address, captured on acceptance so the pc may move freely
    fetch_pkg::pc_t addr_q;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [WSEL_W-1:0]  word_sel;

    logic [`ICACHE_SETS-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q  [`ICACHE_SETS];
    mem_pkg::line_t          data_q [`ICACHE_SETS];

    mem_pkg::line_t  line;
    mem_pkg::laddr_t line_addr;

    logic hit;
    logic accept;
    logic fill;

    assign index    = addr_q[OFFSET_W +: INDEX_W];
    assign tag      = addr_q[OFFSET_W + INDEX_W +: TAG_W];
    assign word_sel = addr_q[OFFSET_W - 1:3];

    assign line = data_q[index];
    assign hit  = valid_q[index] && (tag_q[index] == tag);

    assign line_addr = {addr_q[ADDR_W - 1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign accept = cpu.req_valid && (state_q == ST_IDLE);
    assign fill   = mem.valid && mem.ready;

    // cpu side
    assign cpu.idle       = (state_q == ST_IDLE);
    assign cpu.resp_valid = (state_q == ST_LOOKUP) && hit;
    assign cpu.rdata      = line[{word_sel, 6'd0} +: FWORD_W];

    // memory side, valid comes up already in the lookup cycle of a miss
    assign mem.addr  = line_addr;
    assign mem.valid = ((state_q == ST_LOOKUP) && !hit) || (state_q == ST_REFILL);

    // after a fill the FSM goes back to lookup, which then hits
    // and returns the requested doubleword one cycle after ready
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (cpu.req_valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (!mem.ready) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem.ready) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= cpu.addr;
        end
    end

    // all lines invalid after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index]  <= tag;
            data_q[index] <= mem.rdata;
        end
    end

endmodule

`default_nettype wire

/* ifu/ifu_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_params.svh"

module ifu_fetch (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            dnpc_valid_i,
    input  wire logic            block_i,
    input  wire fetch_pkg::pc_t  dnpc_i,
    input  wire logic            id_en_i,
    output fetch_pkg::pc_t       pc_o,
    output fetch_pkg::instr_t    instr_o,
    output logic                 if_busy_o,
    cpu_cache_if.fetch           cache
);

    fetch_pkg::pc_t    pc_q;
    fetch_pkg::instr_t hold_q;
    fetch_pkg::instr_t resp_half;

    // pend_q means the current pc still has to be sent to the cache
    logic pend_q;
    logic inflight_q;
    logic have_q;

    logic pc_load;
    logic req_accept;
    logic resp_fresh;
    logic consume;

    // a blocked pipeline ignores the next pc entirely
    assign pc_load = dnpc_valid_i && !block_i;

    assign cache.addr      = pc_q;
    assign cache.req_valid = pend_q && !inflight_q;

    assign req_accept = cache.req_valid && cache.idle;

    // pend_q set again while in flight means the pc moved on,
    // so that response belongs to an old pc and is dropped
    assign resp_fresh = cache.resp_valid && !pend_q;

    assign resp_half = pc_q[2] ? cache.rdata[63:32] : cache.rdata[31:0];

    assign if_busy_o = !(have_q || resp_fresh);
    assign consume   = id_en_i && !if_busy_o;

    // fresh data goes straight out, afterwards the held copy
    assign instr_o = resp_fresh ? resp_half : hold_q;
    assign pc_o    = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (pc_load) begin
            pc_q <= dnpc_i;
        end
    end

    // first fetch of the reset pc is pending straight out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q     <= 1'b1;
            inflight_q <= 1'b0;
            have_q     <= 1'b0;
        end else begin
            if (pc_load) begin
                pend_q <= 1'b1;
            end else if (req_accept) begin
                pend_q <= 1'b0;
            end

            // only one fetch in flight at a time
            if (req_accept) begin
                inflight_q <= 1'b1;
            end else if (cache.resp_valid) begin
                inflight_q <= 1'b0;
            end

            // a new pc makes any held instruction stale
            if (pc_load || consume) begin
                have_q <= 1'b0;
            end else if (resp_fresh) begin
                have_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fresh) begin
            hold_q <= resp_half;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  wire logic             clk,
    input  wire logic             rst,

    // next-pc side
    input  wire logic             dnpc_valid_i,
    input  wire logic             block_i,
    input  wire fetch_pkg::pc_t   dnpc_i,

    // decode side
    input  wire logic             id_en_i,
    output fetch_pkg::pc_t        pc_o,
    output fetch_pkg::instr_t     instr_o,
    output logic                  if_busy_o,

    // line refill port to memory
    output logic                  mem_valid_o,
    output mem_pkg::laddr_t       mem_addr_o,
    input  wire mem_pkg::line_t   mem_rdata_i,
    input  wire logic             mem_ready_i
);

    cpu_cache_if cpu_cache_bus ();
    mem_if       mem_bus ();

    ifu_fetch ifu_fetch_inst (
        .clk          (clk),
        .rst          (rst),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .dnpc_i       (dnpc_i),
        .id_en_i      (id_en_i),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .if_busy_o    (if_busy_o),
        .cache        (cpu_cache_bus.fetch)
    );

    icache icache_inst (
        .clk (clk),
        .rst (rst),
        .cpu (cpu_cache_bus.cache),
        .mem (mem_bus.cache)
    );

    // memory bus out to plain ports
    assign mem_valid_o   = mem_bus.valid;
    assign mem_addr_o    = mem_bus.addr;
    assign mem_bus.rdata = mem_rdata_i;
    assign mem_bus.ready = mem_ready_i;

endmodule

`default_nettype wire
